//--- src/frontPkg.sv
////////////////////////////////////////////////////////////////////////////
// front end package: widths and typedefs, reset PC, queue sizing,
// RV32 major opcodes, link registers and the fetch FSM encoding
////////////////////////////////////////////////////////////////////////////

package frontPkg;

	// byte address, also used for every PC
	typedef logic [31:0] addrT;
	// one bus beat, four halfwords from the word-aligned address
	typedef logic [63:0] blockT;
	// aligned instruction window
	typedef logic [31:0] instrT;
	// sign-extended immediate
	typedef logic [31:0] immT;

	// first fetch after reset
	localparam addrT resetPc = 32'h8000_0000;

	// entries towards the decoder
	localparam int queueDepth = 4;
	typedef logic [$clog2(queueDepth)-1:0] queuePtrT;
	// occupancy, needs one extra value for a full queue
	typedef logic [$clog2(queueDepth+1)-1:0] queueCntT;

	// major opcodes of 32-bit control flow
	localparam logic [6:0] opJal = 7'b1101111;
	localparam logic [6:0] opJalr = 7'b1100111;
	localparam logic [6:0] opBranch = 7'b1100011;

	// x1 (ra) and x5 (t0), the standard link registers
	localparam logic [4:0] linkReg1 = 5'd1;
	localparam logic [4:0] linkReg2 = 5'd5;

	// bus master states
	// drain means the data of the running cycle is thrown away
	typedef enum logic [1:0] {
		idle,
		busy,
		drain
	} fetchStateT;

endpackage

//--- src/fetchIf.sv
////////////////////////////////////////////////////////////////////////////
// fetched block from the bus master to the queue, queue full status back
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface fetchIf;
	import frontPkg::*;

	// single cycle pulse, no handshake
	logic valid;
	// pc the block was fetched for, bit 1 selects the window
	addrT pc;
	blockT block;
	// no room for one more block, in-flight one included
	logic full;

	modport source (output valid, pc, block, input full);
	modport sink (input valid, pc, block, output full);

endinterface

//--- src/predecodeIf.sv
////////////////////////////////////////////////////////////////////////////
// predecode bundle from the queue stage back to the PC generator
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface predecodeIf;
	import frontPkg::*;

	// same cycle as the fetched block push
	logic valid;
	logic isJal;
	logic isJalr;
	logic isBranch;
	logic isCall;
	logic isReturn;
	logic isRvc;
	immT imm;

	modport source (output valid, isJal, isJalr, isBranch, isCall, isReturn, isRvc, imm);
	modport sink (input valid, isJal, isJalr, isBranch, isCall, isReturn, isRvc, imm);

endinterface

//--- src/preDecode.sv
////////////////////////////////////////////////////////////////////////////
// combinational predecode: control class, call/return, immediate
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module preDecode (
	input frontPkg::instrT instr,
	output logic isJal,
	output logic isJalr,
	output logic isBranch,
	output logic isCall,
	output logic isReturn,
	output logic isRvc,
	output frontPkg::immT imm
);
	import frontPkg::*;

	logic [6:0] opcode;
	logic [4:0] rd;
	logic [4:0] rs1;
	logic rdLink;
	logic rs1Link;

	assign opcode = instr[6:0];
	assign rd = instr[11:7];
	assign rs1 = instr[19:15];

	// compressed when the low two bits are not 2'b11
	assign isRvc = (instr[1:0] != 2'b11);

	// compressed jumps not decoded, seen as plain instructions
	assign isJal = ~isRvc & (opcode == opJal);
	assign isJalr = ~isRvc & (opcode == opJalr);
	assign isBranch = ~isRvc & (opcode == opBranch);

	assign rdLink = (rd == linkReg1) | (rd == linkReg2);
	assign rs1Link = (rs1 == linkReg1) | (rs1 == linkReg2);

	// push hint, jump and link into ra or t0
	assign isCall = (isJal | isJalr) & rdLink;
	// pop hint, jalr through a link register without linking
	assign isReturn = isJalr & rs1Link & ~rdLink;

	always_comb begin
		if (isJal) begin
			// J-type, offset in halfwords
			imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
		end else if (isBranch) begin
			// B-type
			imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
		end else if (isJalr) begin
			// I-type, offset to rs1
			imm = {{20{instr[31]}}, instr[31:20]};
		end else begin
			imm = '0;
		end
	end

endmodule

//--- src/pcGen.sv
////////////////////////////////////////////////////////////////////////////
// fetch PC register, flush redirect and static next-PC prediction
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pcGen (
	input logic CLK,
	input logic rstN,
	input logic flush,
	input frontPkg::addrT flushPc,
	predecodeIf.sink pd,
	output frontPkg::addrT fetchPc
);
	import frontPkg::*;

	addrT pc;
	addrT pcNext;
	addrT step;
	logic backBranch;
	logic redirect;

	// jalr and returns need a register target
	// without a return stack they fall through
	// backward branch predicted taken
	assign backBranch = pd.isBranch & pd.imm[31];
	// jal always redirects
	assign redirect = pd.isJal | backBranch;

	// sequential step by instruction length
	assign step = pd.isRvc ? addrT'(2) : addrT'(4);

	always_comb begin
		if (redirect) begin
			pcNext = pc + pd.imm;
		end else begin
			pcNext = pc + step;
		end
	end

	// flush wins over a push in the same cycle
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			pc <= resetPc;
		end else if (flush) begin
			pc <= flushPc;
		end else if (pd.valid) begin
			pc <= pcNext;
		end
	end

	// pc only moves on push or flush
	// so it stays put while the bus cycle runs
	assign fetchPc = pc;

endmodule

//--- src/instrFetch.sv
////////////////////////////////////////////////////////////////////////////
// Wishbone classic read master, one 64-bit block per fetch PC
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module instrFetch (
	input logic CLK,
	input logic rstN,
	input logic flush,
	input frontPkg::addrT fetchPc,
	input logic wbAck,
	input frontPkg::blockT wbDatI,
	output logic wbCyc,
	output logic wbStb,
	output frontPkg::addrT wbAdr,
	fetchIf.source fetch
);
	import frontPkg::*;

	fetchStateT state;
	fetchStateT stateNext;
	logic issue;
	logic done;
	logic validQ;
	addrT issuePc;
	blockT blockQ;

	// start only with a free slot, no pulse pending and no flush
	// validQ high is the push cycle, pc is not updated yet
	assign issue = (state == idle) & ~validQ & ~fetch.full & ~flush;
	// good data arrives on ack of a non-flushed cycle
	assign done = (state == busy) & wbAck & ~flush;

	always_comb begin
		stateNext = state;
		case (state)
			idle: begin
				if (issue) begin
					stateNext = busy;
				end
			end
			busy: begin
				// ack together with flush drops the data right away
				if (wbAck) begin
					stateNext = idle;
				end else if (flush) begin
					stateNext = drain;
				end
			end
			drain: begin
				if (wbAck) begin
					stateNext = idle;
				end
			end
			default: stateNext = idle;
		endcase
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			state <= idle;
			validQ <= 1'b0;
		end else begin
			state <= stateNext;
			validQ <= done;
		end
	end

	// issue pc held for the whole cycle, even across a flush
	always_ff @(posedge CLK) begin
		if (issue) begin
			issuePc <= fetchPc;
		end
		if (done) begin
			blockQ <= wbDatI;
		end
	end

	// cyc and stb stay up through busy and drain until ack
	assign wbCyc = (state != idle);
	assign wbStb = (state != idle);
	assign wbAdr = {issuePc[31:2], 2'b00};

	assign fetch.valid = validQ;
	assign fetch.pc = issuePc;
	assign fetch.block = blockQ;

endmodule

//--- src/instrQueue.sv
////////////////////////////////////////////////////////////////////////////
// halfword alignment, predecode and four-entry queue to the decoder
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module instrQueue (
	input logic CLK,
	input logic rstN,
	input logic flush,
	input logic decReady,
	fetchIf.sink fetch,
	predecodeIf.source pd,
	output logic decValid,
	output frontPkg::addrT decPc,
	output frontPkg::instrT decInstr,
	output logic decIsRvc,
	output logic decTaken
);
	import frontPkg::*;

	instrT window;
	instrT entryInstr;
	immT imm;
	logic isJal, isJalr, isBranch, isCall, isReturn, isRvc;
	logic taken, push, pop, reserve;
	queuePtrT wrPtr, rdPtr;
	queueCntT count;
	addrT pcMem [queueDepth];
	instrT instrMem [queueDepth];
	logic rvcMem [queueDepth];
	logic takenMem [queueDepth];

	// pc bit 1 picks the upper window of the block
	assign window = fetch.pc[1] ? fetch.block[47:16] : fetch.block[31:0];

	preDecode preDecode_i (
		.instr(window),
		.isJal(isJal),
		.isJalr(isJalr),
		.isBranch(isBranch),
		.isCall(isCall),
		.isReturn(isReturn),
		.isRvc(isRvc),
		.imm(imm)
	);

	// bundle back to pcGen in the push cycle
	assign pd.valid = fetch.valid;
	assign pd.isJal = isJal;
	assign pd.isJalr = isJalr;
	assign pd.isBranch = isBranch;
	assign pd.isCall = isCall;
	assign pd.isReturn = isReturn;
	assign pd.isRvc = isRvc;
	assign pd.imm = imm;

	// same rule as pcGen, jal or backward branch
	assign taken = isJal | (isBranch & imm[31]);
	// upper half of a compressed window belongs to the next instruction
	assign entryInstr = isRvc ? {16'h0000, window[15:0]} : window;

	assign push = fetch.valid & ~flush;
	assign pop = decValid & decReady;

	// reservation mirrors the master: an idle master issues exactly when
	// full and flush are low, and the block comes back as a valid pulse
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			reserve <= 1'b0;
		end else if (fetch.valid) begin
			reserve <= 1'b0;
		end else if (~fetch.full & ~flush) begin
			reserve <= 1'b1;
		end
	end

	assign fetch.full = (count + queueCntT'(reserve)) >= queueCntT'(queueDepth);

	// flush drops everything at once
	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else if (flush) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			wrPtr <= wrPtr + queuePtrT'(push);
			rdPtr <= rdPtr + queuePtrT'(pop);
			count <= count + queueCntT'(push) - queueCntT'(pop);
		end
	end

	// storage, never overwrites the head while it waits
	always_ff @(posedge CLK) begin
		if (push) begin
			pcMem[wrPtr] <= fetch.pc;
			instrMem[wrPtr] <= entryInstr;
			rvcMem[wrPtr] <= isRvc;
			takenMem[wrPtr] <= taken;
		end
	end

	// head entry, held stable until it is taken
	assign decValid = (count != '0);
	assign decPc = pcMem[rdPtr];
	assign decInstr = instrMem[rdPtr];
	assign decIsRvc = rvcMem[rdPtr];
	assign decTaken = takenMem[rdPtr];

endmodule

//--- src/frontEnd.sv
////////////////////////////////////////////////////////////////////////////
// front end top level with pcGen, instrFetch, instrQueue and their links
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module frontEnd (
	input logic CLK,
	input logic rstN,
	// redirect from the back end
	input logic flush,
	input frontPkg::addrT flushPc,
	// Wishbone classic master
	output logic wbCyc,
	output logic wbStb,
	output frontPkg::addrT wbAdr,
	input frontPkg::blockT wbDatI,
	input logic wbAck,
	// decoder side
	output logic decValid,
	input logic decReady,
	output frontPkg::addrT decPc,
	output frontPkg::instrT decInstr,
	output logic decIsRvc,
	output logic decTaken
);
	import frontPkg::*;

	addrT fetchPc;

	fetchIf fetchBus ();
	predecodeIf pdBus ();

	pcGen pcGen_i (
		.CLK(CLK),
		.rstN(rstN),
		.flush(flush),
		.flushPc(flushPc),
		.pd(pdBus.sink),
		.fetchPc(fetchPc)
	);

	instrFetch instrFetch_i (
		.CLK(CLK),
		.rstN(rstN),
		.flush(flush),
		.fetchPc(fetchPc),
		.wbAck(wbAck),
		.wbDatI(wbDatI),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbAdr(wbAdr),
		.fetch(fetchBus.source)
	);

	instrQueue instrQueue_i (
		.CLK(CLK),
		.rstN(rstN),
		.flush(flush),
		.decReady(decReady),
		.fetch(fetchBus.sink),
		.pd(pdBus.source),
		.decValid(decValid),
		.decPc(decPc),
		.decInstr(decInstr),
		.decIsRvc(decIsRvc),
		.decTaken(decTaken)
	);

endmodule

//--- dv/frontEnd_assert.sv
////////////////////////////////////////////////////////////////////////////
// bound checks on the Wishbone master and the decoder handshake
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module frontEndAssert (
	input logic CLK,
	input logic rstN,
	input logic flush,
	input logic wbCyc,
	input logic wbStb,
	input logic wbAck,
	input logic decValid,
	input logic decReady,
	input frontPkg::addrT decPc,
	input frontPkg::instrT decInstr
);

	// number of failed assertions
	int failCount = 0;

	// strobe only inside a bus cycle
	stbInCyc: assert property (@(posedge CLK) disable iff (!rstN) wbStb |-> wbCyc)
		else begin
			$error("wbStb high without wbCyc");
			failCount++;
		end

	// request held until the slave answers
	stbHold: assert property (@(posedge CLK) disable iff (!rstN) wbStb && !wbAck |=> wbStb)
		else begin
			$error("wbStb dropped before wbAck");
			failCount++;
		end

	// head entry frozen under back-pressure unless flushed
	decHold: assert property (@(posedge CLK) disable iff (!rstN)
		decValid && !decReady && !flush |=> decValid && $stable(decPc) && $stable(decInstr))
		else begin
			$error("decoder output changed while decReady low");
			failCount++;
		end

	// bus quiet in reset
	resetQuiet: assert property (@(posedge CLK) !rstN |-> !wbCyc)
		else begin
			$error("wbCyc high during reset");
			failCount++;
		end

endmodule

bind frontEnd frontEndAssert frontEndAssert_i (
	.CLK(CLK),
	.rstN(rstN),
	.flush(flush),
	.wbCyc(wbCyc),
	.wbStb(wbStb),
	.wbAck(wbAck),
	.decValid(decValid),
	.decReady(decReady),
	.decPc(decPc),
	.decInstr(decInstr)
);

//--- dv/frontEndTb.sv
////////////////////////////////////////////////////////////////////////////
// front end testbench with clock, LFSR stimulus, Wishbone memory model,
// reference PC walk and transfer checker
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module frontEndTb;
	import frontPkg::*;

	logic CLK;
	logic rstN;
	logic flush;
	addrT flushPc;
	logic wbCyc;
	logic wbStb;
	addrT wbAdr;
	blockT wbDatI;
	logic wbAck;
	logic decValid;
	logic decReady;
	addrT decPc;
	instrT decInstr;
	logic decIsRvc;
	logic decTaken;

	logic [31:0] lfsr;
	// 1 KB of halfwords wrapping on address bits 9:0
	logic [15:0] mem [512];
	addrT modelPc;
	addrT lastFlushPc;
	int waiting;
	int waitLeft;
	int stallLeft;
	int transfers;
	int sinceTransfer;
	int mismatches;
	int failures;
	int assertFails;
	logic pendingPush;
	logic cycDrop;
	logic inCycle;
	logic firstIssue;
	logic afterFlush;
	logic timedOut;

	frontEnd frontEnd_i (
		.CLK(CLK),
		.rstN(rstN),
		.flush(flush),
		.flushPc(flushPc),
		.wbCyc(wbCyc),
		.wbStb(wbStb),
		.wbAdr(wbAdr),
		.wbDatI(wbDatI),
		.wbAck(wbAck),
		.decValid(decValid),
		.decReady(decReady),
		.decPc(decPc),
		.decInstr(decInstr),
		.decIsRvc(decIsRvc),
		.decTaken(decTaken)
	);

	// 100 ns period
	always begin
		#50 CLK = ~CLK;
	end

	// galois LFSR stepped once per bit
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		logic lsb;
		int k;
		r = '0;
		for (k = 0; k < n; k++) begin
			lsb = lfsr[0];
			lfsr = lfsr >> 1;
			if (lsb) begin
				lfsr = lfsr ^ 32'h8020_0003;
			end
			r = {r[30:0], lsb};
		end
		return r;
	endfunction

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
			mismatches++;
		end
	endtask

	// weighted mix of control flow, ALU words and compressed halfwords
	task automatic fillMemory();
		int i;
		logic [3:0] kind;
		logic [31:0] r;
		logic [31:0] off;
		logic [31:0] w;
		logic [15:0] c;
		logic [8:0] idx;
		logic [8:0] idxHi;
		i = 0;
		while (i < 512) begin
			kind = randBits(4);
			r = randBits(25);
			off = {23'd0, r[8:1], 1'b0};
			c = '0;
			case (kind)
				// jal with rd ra or x0
				0, 1: begin
					off = kind[0] ? off : -off;
					w = {off[20], off[10:1], off[11], off[19:12], r[9] ? linkReg1 : 5'd0, opJal};
				end
				2: w = {r[24:13], r[12:8], 3'b000, linkReg1, opJalr};
				// return through ra without link
				3: w = {r[24:13], linkReg1, 3'b000, 5'd0, opJalr};
				4, 5, 6, 7: begin
					// upper pair backward and never zero
					off = kind[1] ? -(off + 32'd2) : off;
					w = {off[12], off[10:5], r[24:20], r[19:15], r[14:12], off[4:1], off[11],
						opBranch};
				end
				8, 9, 10, 11: w = {r[24:0], 7'b0110011};
				default: begin
					c = r[15:0];
					if (c[1:0] == 2'b11) begin
						c[1:0] = 2'b10;
					end
					w = {16'h0000, c};
				end
			endcase
			idx = i[8:0];
			idxHi = idx + 9'd1;
			mem[idx] = w[15:0];
			if (kind < 4'd12) begin
				mem[idxHi] = w[31:16];
				i += 2;
			end else begin
				i += 1;
			end
		end
	endtask

	function automatic blockT readBlock(input addrT adr);
		blockT blk;
		logic [8:0] idx;
		int k;
		for (k = 0; k < 4; k++) begin
			idx = adr[9:1] + 9'(k);
			blk[16*k +: 16] = mem[idx];
		end
		return blk;
	endfunction

	// expected entry at pc from the RISC-V encodings
	task automatic modelEntry(input addrT pc, output instrT instr, output logic rvc,
		output logic taken, output addrT nextPc);
		logic [8:0] idx;
		logic [8:0] idxHi;
		instrT win;
		immT imm;
		idx = pc[9:1];
		idxHi = idx + 9'd1;
		win = {mem[idxHi], mem[idx]};
		rvc = (win[1:0] != 2'b11);
		instr = rvc ? {16'h0000, win[15:0]} : win;
		taken = 1'b0;
		imm = '0;
		if (!rvc && win[6:0] == opJal) begin
			imm = {{12{win[31]}}, win[19:12], win[20], win[30:21], 1'b0};
			taken = 1'b1;
		end else if (!rvc && win[6:0] == opBranch) begin
			imm = {{20{win[31]}}, win[7], win[30:25], win[11:8], 1'b0};
			// backward branches predicted taken
			taken = imm[31];
		end
		nextPc = taken ? pc + imm : pc + (rvc ? 32'd2 : 32'd4);
	endtask

	// one clock with drive on the falling edge and checks of this cycle
	task automatic stepCycle(input logic allowFlush);
		instrT expInstr;
		logic expRvc;
		logic expTaken;
		addrT expNext;
		logic transfer;
		logic goodAck;
		@(negedge CLK);
		flush = allowFlush && (randBits(6) == 0);
		flushPc = resetPc + addrT'(randBits(9) << 1);
		if (flush) begin
			decReady = 1'b0;
		end else if (stallLeft > 0) begin
			decReady = 1'b0;
			stallLeft--;
		end else if (randBits(5) == 0) begin
			// long back-pressure stretch
			decReady = 1'b0;
			stallLeft = 8 + int'(randBits(5));
		end else begin
			decReady = (randBits(2) != 0);
		end
		// slave answers after 0 to 3 wait cycles
		wbAck = 1'b0;
		if (wbStb) begin
			if (!inCycle) begin
				inCycle = 1'b1;
				waitLeft = int'(randBits(2));
				if (firstIssue) begin
					checkValue("first wbAdr", resetPc, wbAdr);
					firstIssue = 1'b0;
				end
			end
			if (waitLeft == 0) begin
				wbAck = 1'b1;
				wbDatI = readBlock(wbAdr);
				inCycle = 1'b0;
			end else begin
				waitLeft--;
			end
		end
		// outputs depend on state only and are stable since the rising edge
		transfer = decValid && decReady;
		checkValue("queue valid", 32'(waiting != 0), 32'(decValid));
		if (waiting >= queueDepth) begin
			checkValue("no fetch when full", 32'd0, 32'(wbCyc));
		end
		if (transfer) begin
			if (transfers == 0) begin
				checkValue("reset pc", resetPc, decPc);
			end
			if (afterFlush) begin
				checkValue("flush pc", lastFlushPc, decPc);
			end
			afterFlush = 1'b0;
			modelEntry(modelPc, expInstr, expRvc, expTaken, expNext);
			checkValue("decPc", modelPc, decPc);
			checkValue("decInstr", expInstr, decInstr);
			checkValue("decIsRvc", 32'(expRvc), 32'(decIsRvc));
			checkValue("decTaken", 32'(expTaken), 32'(decTaken));
			modelPc = expNext;
			transfers++;
			sinceTransfer = 0;
		end else begin
			sinceTransfer++;
		end
		// data kept only when the cycle was not hit by a flush
		goodAck = wbCyc && wbAck && !flush && !cycDrop;
		if (wbCyc && wbAck) begin
			cycDrop = 1'b0;
		end else if (wbCyc && flush) begin
			cycDrop = 1'b1;
		end
		if (flush) begin
			waiting = 0;
			modelPc = flushPc;
			lastFlushPc = flushPc;
			afterFlush = 1'b1;
		end else begin
			waiting = waiting + int'(pendingPush) - int'(transfer);
		end
		pendingPush = goodAck;
	endtask

	initial begin
		int count;
		CLK = 1'b0;
		rstN = 1'b0;
		flush = 1'b0;
		flushPc = '0;
		wbAck = 1'b0;
		wbDatI = '0;
		decReady = 1'b0;
		lfsr = 32'h949f5ed9;
		modelPc = resetPc;
		lastFlushPc = resetPc;
		waiting = 0;
		waitLeft = 0;
		stallLeft = 0;
		transfers = 0;
		sinceTransfer = 0;
		mismatches = 0;
		failures = 0;
		assertFails = 0;
		pendingPush = 1'b0;
		cycDrop = 1'b0;
		inCycle = 1'b0;
		firstIssue = 1'b1;
		afterFlush = 1'b0;
		timedOut = 1'b0;
		fillMemory();
		repeat (2) @(negedge CLK);
		rstN = 1'b1;
		// first transfer from the reset pc without flush
		count = 0;
		while (transfers == 0 && count < 100) begin
			stepCycle(1'b0);
			count++;
		end
		if (transfers == 0) begin
			$display("Error: no decoder transfer within 100 cycles after reset");
			failures++;
			timedOut = 1'b1;
		end
		count = 0;
		while (!timedOut && count < 4000) begin
			stepCycle(1'b1);
			count++;
			if (sinceTransfer > 300) begin
				$display("Error: no decoder transfer for 300 cycles");
				failures++;
				timedOut = 1'b1;
			end
		end
		if (transfers < 200) begin
			$display("Error: only %0d decoder transfers seen", transfers);
			failures++;
		end
		assertFails = frontEnd_i.frontEndAssert_i.failCount;
		$display("transfers %0d, mismatches %0d, assertion failures %0d, other errors %0d",
			transfers, mismatches, assertFails, failures);
		if (mismatches == 0 && failures == 0 && assertFails == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- src.f
src/frontPkg.sv
src/fetchIf.sv
src/predecodeIf.sv
src/preDecode.sv
src/pcGen.sv
src/instrFetch.sv
src/instrQueue.sv
src/frontEnd.sv
dv/frontEnd_assert.sv
dv/frontEndTb.sv
